// ==== Bender.yml ====
package:
  name: frame_buffer

export_include_dirs:
  - logic

sources:
  - logic/fb_pkg.sv
  - logic/scan_timing.sv
  - logic/color_plane.sv
  - logic/pixel_out.sv
  - logic/frame_buffer_top.sv
  - target: simulation
    files:
      - bench/frame_buffer_tb.sv

// ==== bench/fb_trace.txt ====
# w <addr> <rgb>  host write, rgb bit 2 red, bit 1 green, bit 0 blue
# e <addr> <rgb>  colour the pixel must show after all writes
w 0000 7
w 0001 4
w 0002 2
w 0003 1
w 0004 7
w 0004 0
w 007f 5
w 0080 3
w 0081 6
w 0100 4
w 0100 2
w 0100 1
w 0a55 7
w 1234 6
w 1fff 3
w 0c40 5
w 03c8 4
w 0050 1
w 0060 2
w 0070 4
w 1f80 7
e 0000 7
e 0001 4
e 0002 2
e 0003 1
e 0004 0
e 007f 5
e 0080 3
e 0081 6
e 0100 1
e 0a55 7
e 1234 6
e 1fff 3
e 0c40 5
e 03c8 4
e 0050 1
e 0060 2
e 0070 4
e 1f80 7
e 0005 0

// ==== bench/frame_buffer_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module frame_buffer_tb;

   import fb_pkg::*;

   localparam int CLK_HALF     = 20;
   localparam int RST_CYCLES   = 8;
   localparam int RAND_WRITES  = 64;
   localparam int FRAME_CYCLES = 21760;       // 160 clocks by 136 lines
   localparam int NUM_PIX      = 16384;
   localparam int H_TOTAL      = `FB_H_TOTAL;
   localparam int H_SYNC_LEN   = `FB_H_SYNC;
   localparam int LINE_PIX     = `FB_H_ACTIVE;
   localparam int FRAME_LINES  = `FB_V_ACTIVE;
   localparam int V_SYNC_LEN   = `FB_V_SYNC * `FB_H_TOTAL;

   logic      clk;
   logic      rst_n;
   logic      wr_en;
   pix_addr_t wr_addr;
   rgb_t      wr_rgb;
   rgb_t      rgb;
   logic      hsync;
   logic      vsync;
   logic      de;

   rgb_t      model [NUM_PIX];       // last write wins
   rgb_t      seen  [NUM_PIX];       // colour shown in the checked frame
   pix_addr_t tw_addr [$];           // trace writes
   rgb_t      tw_rgb  [$];
   pix_addr_t ex_addr [$];           // trace expectations
   rgb_t      ex_rgb  [$];

   int        errors = 0;
   int        pix_checked = 0;
   int        cycles = 0;
   int        timeout_limit;

   frame_buffer_top dut0 (
      .clk     (clk),
      .rst_n   (rst_n),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_rgb  (wr_rgb),
      .rgb     (rgb),
      .hsync   (hsync),
      .vsync   (vsync),
      .de      (de)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #CLK_HALF clk = ~clk;
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_limit) begin
         $display("timeout: no complete checked frame after %0d cycles, errors %0d",
                  timeout_limit, errors);
         $display(">>> FAIL");
         $finish;
      end
   end

   task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                  input logic [31:0] got);
      errors++;
      $display("FAIL t=%0t %s expected %0d got %0d", $time, sig, expected, got);
   endtask

   task automatic report_problem(input string msg);
      errors++;
      $display("ERROR t=%0t %s", $time, msg);
   endtask

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // each trace line holds a kind letter w or e, an address and a colour
   // lines starting with # are comments
   task automatic load_trace();
      int               fd;
      int               rc;
      logic [7:0]       kind;
      logic [31:0]      addr;
      logic [31:0]      col;
      logic [8*128-1:0] rest;
      bit               done;
      fd = $fopen("bench/fb_trace.txt", "r");
      if (fd == 0) begin
         report_problem("cannot open the trace file bench/fb_trace.txt");
      end else begin
         done = 1'b0;
         while (!done) begin
            rc = $fscanf(fd, " %c", kind);
            if (rc != 1) begin
               done = 1'b1;                          // end of file
            end else if (kind == "#") begin
               rc = $fgets(rest, fd);
            end else begin
               rc = $fscanf(fd, "%h %h", addr, col);
               if (rc != 2) begin
                  report_problem("trace line without address and colour");
                  done = 1'b1;
               end else if (kind == "w") begin
                  tw_addr.push_back(pix_addr_t'(addr));
                  tw_rgb.push_back(rgb_t'(col));
               end else if (kind == "e") begin
                  ex_addr.push_back(pix_addr_t'(addr));
                  ex_rgb.push_back(rgb_t'(col));
               end else begin
                  report_problem("trace line of unknown kind");
                  done = 1'b1;
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // reset cycles plus the first cycle after release
   initial begin
      @(posedge clk);                           // outputs unknown before the first reset edge
      repeat (RST_CYCLES + 1) begin
         @(negedge clk);
         if (hsync !== 1'b0) report_mismatch("hsync", 0, hsync);
         if (vsync !== 1'b0) report_mismatch("vsync", 0, vsync);
         if (de !== 1'b0) report_mismatch("de", 0, de);
         if (rgb !== 3'b000) report_mismatch("rgb", 0, rgb);
      end
   end

   initial begin : run_test
      logic [31:0] rnd;
      pix_addr_t   a;
      rgb_t        c;
      int          pix;
      int          de_run;
      int          lines;
      int          hs_rise;
      int          vs_rise;
      bit          hs_seen;
      logic        prev_hs;
      logic        prev_vs;
      logic        prev_de;
      bit          frame_done;

      rst_n   = 1'b0;
      wr_en   = 1'b0;
      wr_addr = '0;
      wr_rgb  = '0;
      for (int i = 0; i < NUM_PIX; i++) begin
         model[i] = '0;                        // planes start black
      end
      load_trace();
      timeout_limit = RST_CYCLES + tw_addr.size() + RAND_WRITES + 3 * FRAME_CYCLES;

      repeat (RST_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      // these land while the first frame is being scanned
      foreach (tw_addr[i]) begin
         @(posedge clk);
         wr_en   <= 1'b1;
         wr_addr <= tw_addr[i];
         wr_rgb  <= tw_rgb[i];
         model[tw_addr[i]] = tw_rgb[i];
      end
      rnd = 32'h0cd1_1541;
      for (int i = 0; i < RAND_WRITES; i++) begin
         rnd = next_random(rnd);
         a = {1'b1, rnd[12:0]};                // rows 64 and up keep clear of trace pixels
         c = rnd[18:16];
         @(posedge clk);
         wr_en   <= 1'b1;
         wr_addr <= a;
         wr_rgb  <= c;
         model[a] = c;
      end
      @(posedge clk);
      wr_en <= 1'b0;

      foreach (ex_addr[i]) begin
         if (model[ex_addr[i]] !== ex_rgb[i]) begin
            report_mismatch($sformatf("model[%0h]", ex_addr[i]), ex_rgb[i], model[ex_addr[i]]);
         end
      end

      // wait for the first vsync to end and the next frame to start
      @(negedge clk);
      prev_vs = vsync;
      vs_rise = -1;
      frame_done = 1'b0;
      while (!frame_done) begin
         @(negedge clk);
         if (vsync && !prev_vs) vs_rise = cycles;
         if (!vsync && prev_vs) frame_done = 1'b1;
         prev_vs = vsync;
      end
      if (vs_rise < 0) report_problem("vsync fell without a rise being seen");
      prev_de = de;
      while (!(de && !prev_de)) begin
         prev_de = de;
         @(negedge clk);
      end

      // walk the checked frame up to the end of its vsync
      pix = 0;
      de_run = 0;
      lines = 0;
      hs_rise = 0;
      hs_seen = 1'b0;
      prev_de = 1'b0;
      prev_hs = hsync;
      prev_vs = vsync;
      frame_done = 1'b0;
      while (!frame_done) begin
         if (de) begin
            if (pix < NUM_PIX) begin
               pix_checked++;
               seen[pix] = rgb;
               if (rgb !== model[pix]) begin
                  report_mismatch($sformatf("rgb at pixel %0h", pix), model[pix], rgb);
               end
            end else begin
               report_problem("de was high for more pixels than the picture holds");
            end
            pix++;
            de_run++;
         end else begin
            if (rgb !== 3'b000) report_mismatch("rgb while de low", 0, rgb);
            if (prev_de) begin
               if (de_run != LINE_PIX) report_mismatch("de run length", LINE_PIX, de_run);
               else lines++;
               de_run = 0;
            end
         end
         if (hsync && !prev_hs) begin
            if (hs_seen && (cycles - hs_rise != H_TOTAL)) begin
               report_mismatch("hsync period", H_TOTAL, cycles - hs_rise);
            end
            hs_rise = cycles;
            hs_seen = 1'b1;
         end
         if (!hsync && prev_hs && hs_seen) begin
            if (cycles - hs_rise != H_SYNC_LEN) begin
               report_mismatch("hsync length", H_SYNC_LEN, cycles - hs_rise);
            end
         end
         if (vsync && !prev_vs) begin
            if (vs_rise >= 0 && (cycles - vs_rise != FRAME_CYCLES)) begin
               report_mismatch("vsync period", FRAME_CYCLES, cycles - vs_rise);
            end
            if (lines != FRAME_LINES) report_mismatch("active lines", FRAME_LINES, lines);
            vs_rise = cycles;
         end
         if (!vsync && prev_vs) begin
            if (cycles - vs_rise != V_SYNC_LEN) begin
               report_mismatch("vsync length", V_SYNC_LEN, cycles - vs_rise);
            end
            frame_done = 1'b1;
         end
         prev_de = de;
         prev_hs = hsync;
         prev_vs = vsync;
         if (!frame_done) @(negedge clk);
      end
      if (pix != NUM_PIX) report_mismatch("pixels per frame", NUM_PIX, pix);

      foreach (ex_addr[i]) begin
         if (seen[ex_addr[i]] !== ex_rgb[i]) begin
            report_mismatch($sformatf("shown rgb[%0h]", ex_addr[i]), ex_rgb[i], seen[ex_addr[i]]);
         end
      end

      $display("pixels checked %0d, writes %0d, expects %0d, errors %0d",
               pix_checked, tw_addr.size() + RAND_WRITES, ex_addr.size(), errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/color_plane.sv ====
`timescale 1ns/1ps
`default_nettype none

module color_plane (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  fb_pkg::pix_addr_t wr_addr,
   input  logic              wr_bit,
   input  logic              rd_en,
   input  fb_pkg::pix_addr_t rd_addr,
   output logic              rd_bit
);

   import fb_pkg::*;

   localparam int DEPTH = 2 ** $bits(pix_addr_t);   // 16384 pixels

   logic mem [DEPTH];

   // picture starts black
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = 1'b0;
      end
   end

   // host side, one bit per write
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_bit;
      end
   end

   // scan side, output register holds while idle
   // a same-cycle write to the read address is seen one read later
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_bit <= 1'b0;
      end else if (rd_en) begin
         rd_bit <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== logic/fb_consts.svh ====
`ifndef FB_CONSTS_SVH
`define FB_CONSTS_SVH

// horizontal timing in pixel clocks
`define FB_H_ACTIVE 128
`define FB_H_FRONT 8
`define FB_H_SYNC 16
`define FB_H_BACK 8
`define FB_H_TOTAL 160     // active + front + sync + back

// vertical timing in lines
`define FB_V_ACTIVE 128
`define FB_V_FRONT 2
`define FB_V_SYNC 3
`define FB_V_BACK 3
`define FB_V_TOTAL 136     // active + front + sync + back

// one plane per colour channel
`define FB_PLANES 3

`endif

// ==== logic/fb_pkg.sv ====
`default_nettype none

package fb_pkg;

   // row times 128 plus column
   typedef logic [13:0] pix_addr_t;

   // horizontal or vertical scan position, wide enough for 0..159
   typedef logic [7:0] coord_t;

   // bit 2 red, bit 1 green, bit 0 blue
   typedef logic [2:0] rgb_t;

endpackage

`default_nettype wire

// ==== logic/frame_buffer_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module frame_buffer_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              wr_en,
   input  fb_pkg::pix_addr_t wr_addr,
   input  fb_pkg::rgb_t      wr_rgb,
   output fb_pkg::rgb_t      rgb,
   output logic              hsync,
   output logic              vsync,
   output logic              de
);

   import fb_pkg::*;

   logic      rd_en;
   pix_addr_t rd_addr;        // shared by all planes
   logic      hsync_early;
   logic      vsync_early;
   logic      de_early;
   rgb_t      plane_bits;     // one bit from each plane

   scan_timing scan_timing0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .rd_en       (rd_en),
      .rd_addr     (rd_addr),
      .hsync_early (hsync_early),
      .vsync_early (vsync_early),
      .de_early    (de_early)
   );

   // plane i stores channel i of the host colour
   for (genvar i = 0; i < `FB_PLANES; i++) begin : g_plane
      color_plane color_plane0 (
         .clk     (clk),
         .rst_n   (rst_n),
         .wr_en   (wr_en),
         .wr_addr (wr_addr),
         .wr_bit  (wr_rgb[i]),
         .rd_en   (rd_en),
         .rd_addr (rd_addr),
         .rd_bit  (plane_bits[i])
      );
   end

   pixel_out pixel_out0 (
      .clk         (clk),
      .rst_n       (rst_n),
      .hsync_early (hsync_early),
      .vsync_early (vsync_early),
      .de_early    (de_early),
      .plane_bits  (plane_bits),
      .rgb         (rgb),
      .hsync       (hsync),
      .vsync       (vsync),
      .de          (de)
   );

endmodule

`default_nettype wire

// ==== logic/pixel_out.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_out (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         hsync_early,
   input  logic         vsync_early,
   input  logic         de_early,
   input  fb_pkg::rgb_t plane_bits,
   output fb_pkg::rgb_t rgb,
   output logic         hsync,
   output logic         vsync,
   output logic         de
);

   import fb_pkg::*;

   logic hsync_d;          // aligned with rd_bit
   logic vsync_d;
   logic de_d;

   rgb_t pix_col;          // colour after blanking

   // outside the picture the read register holds a stale bit
   assign pix_col = de_d ? plane_bits : '0;

   // match the one cycle read latency of the planes
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         hsync_d <= 1'b0;
         vsync_d <= 1'b0;
         de_d    <= 1'b0;
      end else begin
         hsync_d <= hsync_early;
         vsync_d <= vsync_early;
         de_d    <= de_early;
      end
   end

   // output register, colour and syncs leave together
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rgb   <= '0;
         hsync <= 1'b0;
         vsync <= 1'b0;
         de    <= 1'b0;
      end else begin
         rgb   <= pix_col;
         hsync <= hsync_d;
         vsync <= vsync_d;
         de    <= de_d;
      end
   end

endmodule

`default_nettype wire

// ==== logic/scan_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fb_consts.svh"

module scan_timing (
   input  logic              clk,
   input  logic              rst_n,
   output logic              rd_en,
   output fb_pkg::pix_addr_t rd_addr,
   output logic              hsync_early,
   output logic              vsync_early,
   output logic              de_early
);

   import fb_pkg::*;

   localparam int COL_BITS = $clog2(`FB_H_ACTIVE);
   localparam int ROW_BITS = $clog2(`FB_V_ACTIVE);

   // window edges along each axis
   localparam coord_t H_LAST       = coord_t'(`FB_H_TOTAL - 1);
   localparam coord_t V_LAST       = coord_t'(`FB_V_TOTAL - 1);
   localparam coord_t H_ACT_END    = coord_t'(`FB_H_ACTIVE);
   localparam coord_t V_ACT_END    = coord_t'(`FB_V_ACTIVE);
   localparam coord_t H_SYNC_START = coord_t'(`FB_H_ACTIVE + `FB_H_FRONT);
   localparam coord_t H_SYNC_END   = coord_t'(`FB_H_ACTIVE + `FB_H_FRONT + `FB_H_SYNC);
   localparam coord_t V_SYNC_START = coord_t'(`FB_V_ACTIVE + `FB_V_FRONT);
   localparam coord_t V_SYNC_END   = coord_t'(`FB_V_ACTIVE + `FB_V_FRONT + `FB_V_SYNC);

   coord_t h_cnt;          // pixel within line
   coord_t v_cnt;          // line within frame

   logic   h_last;
   logic   v_last;
   logic   h_active;
   logic   v_active;
   logic   pix_active;
   logic   h_sync_win;
   logic   v_sync_win;

   assign h_last = (h_cnt == H_LAST);
   assign v_last = (v_cnt == V_LAST);

   assign h_active   = (h_cnt < H_ACT_END);
   assign v_active   = (v_cnt < V_ACT_END);
   assign pix_active = h_active & v_active;

   assign h_sync_win = (h_cnt >= H_SYNC_START) && (h_cnt < H_SYNC_END);
   assign v_sync_win = (v_cnt >= V_SYNC_START) && (v_cnt < V_SYNC_END);   // whole lines

   // raster counters, vertical steps once per line
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         h_cnt <= '0;
         v_cnt <= '0;
      end else begin
         if (h_last) begin
            h_cnt <= '0;
            if (v_last) begin
               v_cnt <= '0;
            end else begin
               v_cnt <= v_cnt + 1'b1;
            end
         end else begin
            h_cnt <= h_cnt + 1'b1;
         end
      end
   end

   // decoded strobes describe the pixel at the current counters
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         rd_en       <= 1'b0;
         de_early    <= 1'b0;
         hsync_early <= 1'b0;
         vsync_early <= 1'b0;
      end else begin
         rd_en       <= pix_active;      // memory only read in the picture
         de_early    <= pix_active;
         hsync_early <= h_sync_win;
         vsync_early <= v_sync_win;
      end
   end

   // address is only sampled while rd_en is high
   always_ff @(posedge clk) begin
      rd_addr <= {v_cnt[ROW_BITS-1:0], h_cnt[COL_BITS-1:0]};
   end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+logic
logic/fb_pkg.sv
logic/scan_timing.sv
logic/color_plane.sv
logic/pixel_out.sv
logic/frame_buffer_top.sv
bench/frame_buffer_tb.sv
